// ==== Bender.yml ====
package:
  name: cpu_top

sources:
  - design/cpu_isa_pkg.sv
  - design/cpu_pipe_pkg.sv
  - design/alu.sv
  - design/regfile.sv
  - design/fetch_stage.sv
  - design/decode_stage.sv
  - design/hazard_forwarding_unit.sv
  - design/execute_stage.sv
  - design/mem_wb_stage.sv
  - design/cpu_top.sv
  - target: simulation
    files:
      - sim/cpu_tb.sv

// ==== build.f ====
design/cpu_isa_pkg.sv
design/cpu_pipe_pkg.sv
design/alu.sv
design/regfile.sv
design/fetch_stage.sv
design/decode_stage.sv
design/hazard_forwarding_unit.sv
design/execute_stage.sv
design/mem_wb_stage.sv
design/cpu_top.sv
sim/cpu_tb.sv

// ==== design/alu.sv ====
`timescale 1ns/1ps

module alu
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
    input  data_t   a,
    input  data_t   b,
    input  alu_op_e op,
    output data_t   y,
    output flags_t  flags
);

    logic [8:0] res;

    always_comb begin
        case (op)
            ALU_ADD: res = {1'b0, a} + {1'b0, b};
            // Bit 8 ends up as the borrow
            ALU_SUB: res = {1'b0, a} - {1'b0, b};
            ALU_AND: res = {1'b0, a & b};
            ALU_OR:  res = {1'b0, a | b};
            ALU_INC: res = {1'b0, a} + 9'd1;
            default: res = {1'b0, b};
        endcase
    end

    assign y       = res[7:0];
    assign flags.z = (res[7:0] == 8'd0);
    assign flags.n = res[7];
    assign flags.c = res[8];

endmodule

// ==== design/cpu_isa_pkg.sv ====
package cpu_isa_pkg;

    typedef logic [7:0] data_t;
    typedef logic [1:0] reg_idx_t;

    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_MOV = 4'd1,
        OP_ADD = 4'd2,
        OP_SUB = 4'd3,
        OP_AND = 4'd4,
        OP_OR  = 4'd5,
        OP_INC = 4'd6,
        OP_LDM = 4'd7,
        OP_LD  = 4'd8,
        OP_ST  = 4'd9,
        OP_IN  = 4'd10,
        OP_OUT = 4'd11,
        OP_JMP = 4'd12,
        OP_HLT = 4'd15
    } opcode_e;

    typedef enum logic [1:0] {
        COND_ALWAYS = 2'd0,
        COND_Z      = 2'd1,
        COND_N      = 2'd2,
        COND_C      = 2'd3
    } cond_e;

    typedef struct packed {
        opcode_e  opcode;
        reg_idx_t ra;
        reg_idx_t rb;
    } instr_reg_t;

    // Jump reuses the ra field as its condition
    typedef struct packed {
        opcode_e  opcode;
        cond_e    cond;
        reg_idx_t rb;
    } instr_jmp_t;

    typedef union packed {
        instr_reg_t r;
        instr_jmp_t j;
    } instr_u;

    typedef struct packed {
        logic z;
        logic n;
        logic c;
    } flags_t;

endpackage

// ==== design/cpu_pipe_pkg.sv ====
package cpu_pipe_pkg;

    import cpu_isa_pkg::*;

    typedef enum logic [2:0] {
        ALU_PASS_B = 3'd0,
        ALU_ADD    = 3'd1,
        ALU_SUB    = 3'd2,
        ALU_AND    = 3'd3,
        ALU_OR     = 3'd4,
        ALU_INC    = 3'd5
    } alu_op_e;

    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_MEM = 2'd1,
        WB_IN  = 2'd2
    } wb_src_e;

    // Operand select encodings, hazard unit to execute
    localparam logic [1:0] FWD_LATCH = 2'd0;
    localparam logic [1:0] FWD_MEM   = 2'd1;
    localparam logic [1:0] FWD_WB    = 2'd2;

    typedef struct packed {
        logic    reg_we;
        logic    mem_we;
        logic    mem_rd;
        logic    out_ld;
        logic    hlt;
        logic    flag_we;
        logic    is_jmp;
        alu_op_e alu_op;
        wb_src_e wb_src;
    } ctrl_t;

    typedef struct packed {
        data_t instr;
        logic  vld;
        logic  imm;
    } if_d_t;

    typedef struct packed {
        ctrl_t    ctrl;
        cond_e    cond;
        reg_idx_t ra;
        reg_idx_t rb;
        data_t    a;
        data_t    b;
        logic     imm_vld;
    } d_ex_t;

    typedef struct packed {
        logic     reg_we;
        logic     mem_we;
        logic     out_ld;
        logic     hlt;
        wb_src_e  wb_src;
        reg_idx_t rd;
        data_t    result;
        data_t    sdata;
    } ex_m_t;

    typedef struct packed {
        logic     reg_we;
        reg_idx_t rd;
        data_t    data;
    } m_wb_t;

endpackage

// ==== design/cpu_top.sv ====
`timescale 1ns/1ps

module cpu_top
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
#(
    parameter int IMEM_DEPTH = 64,
    parameter int DMEM_DEPTH = 32
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  prog_we,
    input  data_t prog_addr,
    input  data_t prog_data,
    input  data_t in_port,
    output data_t out_port,
    output logic  out_valid,
    output logic  hlt
);

    if_d_t      if_d;
    d_ex_t      d_ex;
    ex_m_t      ex_m;
    m_wb_t      m_wb;
    reg_idx_t   rs_a;
    reg_idx_t   rs_b;
    logic [1:0] fwd_a;
    logic [1:0] fwd_b;
    logic       stall;
    logic       redirect;
    data_t      target;

    fetch_stage #(
        .IMEM_DEPTH (IMEM_DEPTH)
    ) u_fetch (
        .clk       (clk),
        .rst_n     (rst_n),
        .stall     (stall),
        .redirect  (redirect),
        .target    (target),
        .halted    (hlt),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .if_d      (if_d)
    );

    decode_stage u_decode (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_d     (if_d),
        .stall    (stall),
        .redirect (redirect),
        .m_wb     (m_wb),
        .d_ex     (d_ex),
        .rs_a     (rs_a),
        .rs_b     (rs_b)
    );

    hazard_forwarding_unit u_hfu (
        .rs_a  (rs_a),
        .rs_b  (rs_b),
        .d_ex  (d_ex),
        .ex_m  (ex_m),
        .m_wb  (m_wb),
        .fwd_a (fwd_a),
        .fwd_b (fwd_b),
        .stall (stall)
    );

    execute_stage u_execute (
        .clk      (clk),
        .rst_n    (rst_n),
        .d_ex     (d_ex),
        .fwd_a    (fwd_a),
        .fwd_b    (fwd_b),
        .ex_m_fb  (ex_m),
        .m_wb_fb  (m_wb),
        .ex_m     (ex_m),
        .redirect (redirect),
        .target   (target)
    );

    mem_wb_stage #(
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_mem_wb (
        .clk       (clk),
        .rst_n     (rst_n),
        .ex_m      (ex_m),
        .in_port   (in_port),
        .m_wb      (m_wb),
        .out_port  (out_port),
        .out_valid (out_valid),
        .hlt       (hlt)
    );

endmodule

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps

module decode_stage
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  if_d_t    if_d,
    input  logic     stall,
    input  logic     redirect,
    input  m_wb_t    m_wb,
    output d_ex_t    d_ex,
    output reg_idx_t rs_a,
    output reg_idx_t rs_b
);

    instr_u   ins;
    opcode_e  op;
    ctrl_t    ctrl;
    reg_idx_t ldm_rd;
    data_t    rd_a;
    data_t    rd_b;
    logic     is_imm;

    assign ins    = if_d.instr;
    assign op     = ins.r.opcode;
    assign rs_a   = ins.r.ra;
    assign rs_b   = ins.j.rb;
    assign is_imm = if_d.vld && if_d.imm;

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .ra    (rs_a),
        .rb    (rs_b),
        .wr    (m_wb),
        .rd_a  (rd_a),
        .rd_b  (rd_b)
    );

    always_comb begin
        ctrl = '0;
        if (is_imm) begin
            // Completed LDM, immediate passes through the ALU
            ctrl.reg_we = 1'b1;
            ctrl.alu_op = ALU_PASS_B;
        end else if (if_d.vld) begin
            case (op)
                OP_MOV: ctrl.reg_we = 1'b1;
                OP_ADD, OP_SUB, OP_AND, OP_OR, OP_INC: begin
                    ctrl.reg_we  = 1'b1;
                    ctrl.flag_we = 1'b1;
                    case (op)
                        OP_ADD:  ctrl.alu_op = ALU_ADD;
                        OP_SUB:  ctrl.alu_op = ALU_SUB;
                        OP_AND:  ctrl.alu_op = ALU_AND;
                        OP_OR:   ctrl.alu_op = ALU_OR;
                        default: ctrl.alu_op = ALU_INC;
                    endcase
                end
                OP_LD: begin
                    ctrl.reg_we = 1'b1;
                    ctrl.mem_rd = 1'b1;
                    ctrl.wb_src = WB_MEM;
                end
                OP_ST:  ctrl.mem_we = 1'b1;
                OP_IN: begin
                    ctrl.reg_we = 1'b1;
                    ctrl.wb_src = WB_IN;
                end
                OP_OUT: ctrl.out_ld = 1'b1;
                OP_JMP: ctrl.is_jmp = 1'b1;
                OP_HLT: ctrl.hlt    = 1'b1;
                default: ctrl = '0;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            d_ex   <= '0;
            ldm_rd <= '0;
        end else begin
            if (if_d.vld && !if_d.imm && op == OP_LDM) begin
                ldm_rd <= ins.r.ra;
            end
            if (stall || redirect) begin
                d_ex <= '0;
            end else begin
                d_ex.ctrl    <= ctrl;
                d_ex.cond    <= ins.j.cond;
                d_ex.ra      <= is_imm ? ldm_rd : ins.r.ra;
                d_ex.rb      <= ins.r.rb;
                d_ex.a       <= rd_a;
                d_ex.b       <= is_imm ? if_d.instr : rd_b;
                d_ex.imm_vld <= is_imm;
            end
        end
    end

endmodule

// ==== design/execute_stage.sv ====
`timescale 1ns/1ps

module execute_stage
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  d_ex_t      d_ex,
    input  logic [1:0] fwd_a,
    input  logic [1:0] fwd_b,
    input  ex_m_t      ex_m_fb,
    input  m_wb_t      m_wb_fb,
    output ex_m_t      ex_m,
    output logic       redirect,
    output data_t      target
);

    data_t  op_a;
    data_t  op_b;
    data_t  alu_y;
    flags_t alu_flags;
    flags_t flag_q;
    logic   cond_ok;

    always_comb begin
        case (fwd_a)
            FWD_MEM: op_a = ex_m_fb.result;
            FWD_WB:  op_a = m_wb_fb.data;
            default: op_a = d_ex.a;
        endcase
        // LDM immediate is never forwarded over
        if (d_ex.imm_vld) begin
            op_b = d_ex.b;
        end else begin
            case (fwd_b)
                FWD_MEM: op_b = ex_m_fb.result;
                FWD_WB:  op_b = m_wb_fb.data;
                default: op_b = d_ex.b;
            endcase
        end
    end

    alu u_alu (
        .a     (op_a),
        .b     (op_b),
        .op    (d_ex.ctrl.alu_op),
        .y     (alu_y),
        .flags (alu_flags)
    );

    always_comb begin
        case (d_ex.cond)
            COND_Z:  cond_ok = flag_q.z;
            COND_N:  cond_ok = flag_q.n;
            COND_C:  cond_ok = flag_q.c;
            default: cond_ok = 1'b1;
        endcase
    end

    assign redirect = d_ex.ctrl.is_jmp && cond_ok;
    assign target   = op_b;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            flag_q <= '0;
            ex_m   <= '0;
        end else begin
            if (d_ex.ctrl.flag_we) begin
                flag_q <= alu_flags;
            end
            ex_m <= '{reg_we: d_ex.ctrl.reg_we, mem_we: d_ex.ctrl.mem_we,
                      out_ld: d_ex.ctrl.out_ld, hlt: d_ex.ctrl.hlt,
                      wb_src: d_ex.ctrl.wb_src, rd: d_ex.ra,
                      result: alu_y, sdata: op_a};
        end
    end

endmodule

// ==== design/fetch_stage.sv ====
`timescale 1ns/1ps

module fetch_stage
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
#(
    parameter int IMEM_DEPTH = 64
) (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  stall,
    input  logic  redirect,
    input  data_t target,
    input  logic  halted,
    input  logic  prog_we,
    input  data_t prog_addr,
    input  data_t prog_data,
    output if_d_t if_d
);

    localparam int IAW = $clog2(IMEM_DEPTH);

    data_t  imem [IMEM_DEPTH];
    data_t  pc;
    instr_u fbyte;
    logic   imm_next;

    // Program port, used while the core sits in reset
    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr[IAW-1:0]] <= prog_data;
        end
    end

    assign fbyte = imem[pc[IAW-1:0]];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc       <= '0;
            imm_next <= 1'b0;
            if_d     <= '0;
        end else if (redirect) begin
            pc       <= target;
            imm_next <= 1'b0;
            if_d     <= '0;
        end else if (halted) begin
            if_d <= '0;
        end else if (!stall) begin
            if_d.instr <= fbyte;
            if_d.vld   <= 1'b1;
            if_d.imm   <= imm_next;
            // Byte after an LDM opcode is its immediate
            imm_next   <= !imm_next && (fbyte.r.opcode == OP_LDM);
            pc         <= pc + 8'd1;
        end
    end

endmodule

// ==== design/hazard_forwarding_unit.sv ====
`timescale 1ns/1ps

module hazard_forwarding_unit
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
    input  reg_idx_t   rs_a,
    input  reg_idx_t   rs_b,
    input  d_ex_t      d_ex,
    input  ex_m_t      ex_m,
    input  m_wb_t      m_wb,
    output logic [1:0] fwd_a,
    output logic [1:0] fwd_b,
    output logic       stall
);

    // Memory stage wins, it holds the younger value
    function automatic logic [1:0] fwd_sel(reg_idx_t src);
        if (ex_m.reg_we && ex_m.wb_src == WB_ALU && ex_m.rd == src) begin
            return FWD_MEM;
        end
        if (m_wb.reg_we && m_wb.rd == src) begin
            return FWD_WB;
        end
        return FWD_LATCH;
    endfunction

    assign fwd_a = fwd_sel(d_ex.ra);
    assign fwd_b = fwd_sel(d_ex.rb);

    // LD and IN only have their data at the memory stage
    assign stall = (d_ex.ctrl.mem_rd || (d_ex.ctrl.reg_we && d_ex.ctrl.wb_src == WB_IN))
                   && (d_ex.ra == rs_a || d_ex.ra == rs_b);

endmodule

// ==== design/mem_wb_stage.sv ====
`timescale 1ns/1ps

module mem_wb_stage
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
#(
    parameter int DMEM_DEPTH = 32
) (
    input  logic  clk,
    input  logic  rst_n,
    input  ex_m_t ex_m,
    input  data_t in_port,
    output m_wb_t m_wb,
    output data_t out_port,
    output logic  out_valid,
    output logic  hlt
);

    localparam int DAW = $clog2(DMEM_DEPTH);

    data_t          dmem [DMEM_DEPTH];
    logic [DAW-1:0] daddr;
    data_t          wb_data;

    assign daddr = ex_m.result[DAW-1:0];

    always_comb begin
        case (ex_m.wb_src)
            WB_MEM:  wb_data = dmem[daddr];
            WB_IN:   wb_data = in_port;
            default: wb_data = ex_m.result;
        endcase
    end

    always_ff @(posedge clk) begin
        if (ex_m.mem_we && !hlt) begin
            dmem[daddr] <= ex_m.sdata;
        end
    end

    // Once halted, everything still in flight is dropped here
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_wb      <= '0;
            out_port  <= '0;
            out_valid <= 1'b0;
            hlt       <= 1'b0;
        end else begin
            out_valid <= 1'b0;
            if (hlt) begin
                m_wb <= '0;
            end else begin
                m_wb <= '{reg_we: ex_m.reg_we, rd: ex_m.rd, data: wb_data};
                if (ex_m.out_ld) begin
                    out_port  <= ex_m.sdata;
                    out_valid <= 1'b1;
                end
                if (ex_m.hlt) begin
                    hlt <= 1'b1;
                end
            end
        end
    end

endmodule

// ==== design/regfile.sv ====
`timescale 1ns/1ps

module regfile
    import cpu_isa_pkg::*, cpu_pipe_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  reg_idx_t ra,
    input  reg_idx_t rb,
    input  m_wb_t    wr,
    output data_t    rd_a,
    output data_t    rd_b
);

    data_t regs [4];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 4; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.reg_we) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // Write-through so decode sees the write-back in the same cycle
    assign rd_a = (wr.reg_we && wr.rd == ra) ? wr.data : regs[ra];
    assign rd_b = (wr.reg_we && wr.rd == rb) ? wr.data : regs[rb];

endmodule

// ==== sim/cpu_tb.sv ====
`timescale 1ns/1ps

module cpu_tb
    import cpu_isa_pkg::*;
;

    localparam int IMEM_DEPTH       = 64;
    localparam int DMEM_DEPTH       = 32;
    localparam int CLK_PERIOD       = 40;
    localparam int RESET_CYCLES     = 10;
    localparam int PAD_BYTES        = 4;
    localparam int POST_HALT_CYCLES = 8;
    localparam int NUM_RUNS         = 7;
    // Each run bounded by a full instruction memory at 8 cycles per byte
    localparam int WATCHDOG_CYCLES  =
        NUM_RUNS * (IMEM_DEPTH * 8 + RESET_CYCLES + POST_HALT_CYCLES) + RESET_CYCLES;

    logic  clk;
    logic  rst_n;
    logic  prog_we;
    data_t prog_addr;
    data_t prog_data;
    data_t in_port;
    data_t out_port;
    logic  out_valid;
    logic  hlt;

    integer seed = 32'h5cbd;
    int     errors;
    int     checks;
    data_t  prog [$];
    data_t  exp_q [$];

    cpu_top #(
        .IMEM_DEPTH (IMEM_DEPTH),
        .DMEM_DEPTH (DMEM_DEPTH)
    ) u_dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .in_port   (in_port),
        .out_port  (out_port),
        .out_valid (out_valid),
        .hlt       (hlt)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: the core did not halt within %0d cycles", WATCHDOG_CYCLES);
        $display("Testbench failed");
        $finish;
    end

    function automatic data_t rand_byte();
        integer r;
        r = $random(seed);
        return r[7:0];
    endfunction

    function automatic data_t encode_rr(opcode_e op, reg_idx_t ra, reg_idx_t rb);
        instr_u u;
        u.r.opcode = op;
        u.r.ra     = ra;
        u.r.rb     = rb;
        return u;
    endfunction

    // HLT with low bits taken from the whole address
    function automatic data_t pad_byte(int addr);
        data_t a;
        data_t x;
        a = data_t'(addr);
        x = {4'h0, a[3:0] ^ a[7:4]};
        return encode_rr(OP_HLT, x[3:2], x[1:0]);
    endfunction

    function automatic data_t prog_byte(data_t addr);
        if (addr < prog.size()) begin
            return prog[addr];
        end
        return pad_byte(addr);
    endfunction

    task automatic add_instr(input opcode_e op, input reg_idx_t ra, input reg_idx_t rb);
        prog.push_back(encode_rr(op, ra, rb));
    endtask

    task automatic load_imm(input reg_idx_t rd, input data_t imm);
        prog.push_back(encode_rr(OP_LDM, rd, 2'd0));
        prog.push_back(imm);
    endtask

    task automatic jump_on(input cond_e cond, input reg_idx_t rb);
        instr_u u;
        u.j.opcode = OP_JMP;
        u.j.cond   = cond;
        u.j.rb     = rb;
        prog.push_back(u);
    endtask

    task automatic check_data(input string name, input data_t got, input data_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%02h, expected 0x%02h", name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    task automatic check_count(input string name, input int got, input int exp);
        checks++;
        if (got != exp) begin
            errors++;
            $display("ERROR %s: got 0x%0h, expected 0x%0h", name, got, exp);
        end
    endtask

    // Instruction-level model, one instruction at a time
    task automatic model_program(input data_t in_val);
        data_t    r [4];
        data_t    dm [DMEM_DEPTH];
        data_t    pc;
        data_t    res;
        instr_u   ins;
        reg_idx_t ra;
        reg_idx_t rb;
        flags_t   f;
        logic     cy;
        logic     is_alu;
        logic     take;
        logic     done;
        int       steps;
        exp_q.delete();
        for (int i = 0; i < 4; i++) begin
            r[i] = '0;
        end
        f     = '0;
        pc    = '0;
        done  = 1'b0;
        steps = 0;
        while (!done && steps < 512) begin
            ins    = prog_byte(pc);
            ra     = ins.r.ra;
            rb     = ins.r.rb;
            pc     = pc + 8'd1;
            steps  = steps + 1;
            is_alu = 1'b0;
            case (ins.r.opcode)
                OP_MOV: r[ra] = r[rb];
                OP_ADD: begin
                    {cy, res} = {1'b0, r[ra]} + {1'b0, r[rb]};
                    is_alu = 1'b1;
                end
                OP_SUB: begin
                    res    = r[ra] - r[rb];
                    cy     = r[ra] < r[rb];
                    is_alu = 1'b1;
                end
                OP_AND: begin
                    res    = r[ra] & r[rb];
                    cy     = 1'b0;
                    is_alu = 1'b1;
                end
                OP_OR: begin
                    res    = r[ra] | r[rb];
                    cy     = 1'b0;
                    is_alu = 1'b1;
                end
                OP_INC: begin
                    res    = r[ra] + 8'd1;
                    cy     = (r[ra] == 8'hff);
                    is_alu = 1'b1;
                end
                OP_LDM: begin
                    r[ra] = prog_byte(pc);
                    pc    = pc + 8'd1;
                end
                OP_LD:  r[ra] = dm[r[rb] % DMEM_DEPTH];
                OP_ST:  dm[r[rb] % DMEM_DEPTH] = r[ra];
                OP_IN:  r[ra] = in_val;
                OP_OUT: exp_q.push_back(r[ra]);
                OP_JMP: begin
                    case (ins.j.cond)
                        COND_Z:  take = f.z;
                        COND_N:  take = f.n;
                        COND_C:  take = f.c;
                        default: take = 1'b1;
                    endcase
                    if (take) begin
                        pc = r[rb];
                    end
                end
                OP_HLT: done = 1'b1;
                default: ;
            endcase
            if (is_alu) begin
                r[ra] = res;
                f.z   = (res == 8'd0);
                f.n   = res[7];
                f.c   = cy;
            end
        end
    endtask

    task automatic write_program();
        int total;
        total = prog.size() + PAD_BYTES;
        for (int a = 0; a < total; a++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = data_t'(a);
            prog_data = prog_byte(data_t'(a));
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    // Load under reset, run to halt, compare against the model
    task automatic run_program(input string name, input data_t in_val);
        data_t got [$];
        @(negedge clk);
        rst_n   = 1'b0;
        in_port = in_val;
        write_program();
        repeat (RESET_CYCLES) @(negedge clk);
        rst_n = 1'b1;
        do begin
            @(negedge clk);
            if (out_valid) begin
                got.push_back(out_port);
            end
        end while (!hlt);
        repeat (POST_HALT_CYCLES) begin
            @(negedge clk);
            check_bit({name, " out_valid after halt"}, out_valid, 1'b0);
            check_bit({name, " hlt"}, hlt, 1'b1);
        end
        model_program(in_val);
        check_count({name, " output count"}, got.size(), exp_q.size());
        for (int i = 0; i < got.size() && i < exp_q.size(); i++) begin
            check_data($sformatf("%s out_port[%0d]", name, i), got[i], exp_q[i]);
        end
        prog.delete();
    endtask

    task automatic test_alu_ops();
        opcode_e ops [5] = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_INC};
        for (int i = 0; i < 5; i++) begin
            load_imm(2'd0, rand_byte());
            load_imm(2'd1, rand_byte());
            add_instr(ops[i], 2'd0, 2'd1);
            add_instr(OP_OUT, 2'd0, 2'd0);
        end
        add_instr(OP_HLT, 2'd0, 2'd0);
        run_program("alu", 8'h00);
    endtask

    task automatic test_forwarding();
        load_imm(2'd0, rand_byte());
        load_imm(2'd1, rand_byte());
        // Back to back, memory-stage path
        add_instr(OP_ADD, 2'd0, 2'd1);
        add_instr(OP_ADD, 2'd0, 2'd0);
        add_instr(OP_OUT, 2'd0, 2'd0);
        // One apart, write-back path
        add_instr(OP_MOV, 2'd2, 2'd0);
        add_instr(OP_NOP, 2'd0, 2'd0);
        add_instr(OP_SUB, 2'd2, 2'd1);
        add_instr(OP_NOP, 2'd0, 2'd0);
        add_instr(OP_NOP, 2'd0, 2'd0);
        add_instr(OP_OR, 2'd2, 2'd0);
        add_instr(OP_OUT, 2'd2, 2'd0);
        add_instr(OP_INC, 2'd3, 2'd0);
        add_instr(OP_INC, 2'd3, 2'd0);
        add_instr(OP_INC, 2'd3, 2'd0);
        add_instr(OP_OUT, 2'd3, 2'd0);
        add_instr(OP_MOV, 2'd1, 2'd3);
        add_instr(OP_ADD, 2'd1, 2'd2);
        add_instr(OP_OUT, 2'd1, 2'd0);
        add_instr(OP_HLT, 2'd0, 2'd0);
        run_program("forwarding", 8'h00);
    endtask

    task automatic test_memory();
        load_imm(2'd0, 8'h05);
        load_imm(2'd1, rand_byte());
        add_instr(OP_ST, 2'd1, 2'd0);
        add_instr(OP_LD, 2'd2, 2'd0);
        add_instr(OP_OUT, 2'd2, 2'd0);
        add_instr(OP_LD, 2'd3, 2'd0);
        add_instr(OP_ADD, 2'd3, 2'd1);
        add_instr(OP_OUT, 2'd3, 2'd0);
        // Loaded byte used as the next load address
        load_imm(2'd0, 8'h1a);
        load_imm(2'd1, 8'h09);
        add_instr(OP_ST, 2'd1, 2'd0);
        load_imm(2'd2, rand_byte());
        add_instr(OP_ST, 2'd2, 2'd1);
        add_instr(OP_LD, 2'd3, 2'd0);
        add_instr(OP_LD, 2'd3, 2'd3);
        add_instr(OP_OUT, 2'd3, 2'd0);
        add_instr(OP_HLT, 2'd0, 2'd0);
        run_program("memory", 8'h00);
    endtask

    // Flag-setting op then a jump over two OUTs to a third OUT
    task automatic jump_case(input cond_e cond, input opcode_e op, input data_t a,
                             input data_t b);
        data_t tgt;
        load_imm(2'd0, a);
        load_imm(2'd1, b);
        tgt = data_t'(prog.size() + 6);
        load_imm(2'd3, tgt);
        add_instr(op, 2'd0, 2'd1);
        jump_on(cond, 2'd3);
        add_instr(OP_OUT, 2'd0, 2'd0);
        add_instr(OP_OUT, 2'd1, 2'd0);
        add_instr(OP_OUT, 2'd3, 2'd0);
    endtask

    task automatic test_jumps();
        jump_case(COND_Z, OP_SUB, 8'h07, 8'h07);
        jump_case(COND_Z, OP_SUB, 8'h07, 8'h06);
        jump_case(COND_N, OP_SUB, 8'h03, 8'h05);
        jump_case(COND_N, OP_SUB, 8'h05, 8'h03);
        add_instr(OP_HLT, 2'd0, 2'd0);
        run_program("jump z/n", 8'h00);
        jump_case(COND_C, OP_ADD, 8'hf0, 8'h20);
        jump_case(COND_C, OP_ADD, 8'h01, 8'h02);
        jump_case(COND_ALWAYS, OP_AND, 8'h0f, 8'h3c);
        add_instr(OP_HLT, 2'd0, 2'd0);
        run_program("jump c/always", 8'h00);
    endtask

    task automatic test_in_port();
        add_instr(OP_IN, 2'd2, 2'd0);
        add_instr(OP_OUT, 2'd2, 2'd0);
        add_instr(OP_IN, 2'd1, 2'd0);
        add_instr(OP_ADD, 2'd1, 2'd2);
        add_instr(OP_OUT, 2'd1, 2'd0);
        load_imm(2'd0, 8'h33);
        add_instr(OP_IN, 2'd0, 2'd0);
        add_instr(OP_MOV, 2'd3, 2'd0);
        add_instr(OP_OUT, 2'd3, 2'd0);
        add_instr(OP_HLT, 2'd0, 2'd0);
        run_program("in_port", rand_byte());
    endtask

    task automatic test_halt();
        load_imm(2'd0, rand_byte());
        add_instr(OP_OUT, 2'd0, 2'd0);
        add_instr(OP_HLT, 2'd0, 2'd0);
        add_instr(OP_OUT, 2'd0, 2'd0);
        add_instr(OP_INC, 2'd0, 2'd0);
        add_instr(OP_OUT, 2'd0, 2'd0);
        add_instr(OP_OUT, 2'd0, 2'd0);
        run_program("halt", 8'h00);
        @(negedge clk);
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(negedge clk);
        check_bit("hlt after reset", hlt, 1'b0);
        // Program is still loaded, reset lands inside its output pulse
        rst_n = 1'b1;
        do begin
            @(negedge clk);
        end while (!out_valid);
        rst_n = 1'b0;
        #(CLK_PERIOD / 4);
        check_bit("out_valid after reset", out_valid, 1'b0);
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        in_port   = '0;
        errors    = 0;
        checks    = 0;
        repeat (RESET_CYCLES) @(negedge clk);
        test_alu_ops();
        test_forwarding();
        test_memory();
        test_jumps();
        test_in_port();
        test_halt();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule
